// ==== fg.f ====
+incdir+common
common/fg_pkg.sv
loader/pattern_loader.sv
channel/playback_channel.sv
serializer/word_serializer.sv
verilog/fg_top.sv
bench/fg_tb.sv

// ==== Bender.yml ====
package:
  name: fg

sources:
  # design sources, package first
  - include_dirs:
      - common
    files:
      - common/fg_pkg.sv
      - loader/pattern_loader.sv
      - channel/playback_channel.sv
      - serializer/word_serializer.sv
      - verilog/fg_top.sv

  # testbench
  - target: test
    include_dirs:
      - common
    files:
      - bench/fg_tb.sv

// ==== bench/fg_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fg_cfg.svh"

module fg_tb;

	localparam int WORDS = 2**`FG_ADDR_BITS;
	localparam int LOAD_CYCLES = `FG_CHANNELS * WORDS;
	// load plus four window passes, with margin
	localparam int TIMEOUT_CYCLES = 4000;
	// fewest rebuilt words that still reach every check
	localparam int MIN_WORDS = 80;

	logic clock50 = 1'b0;
	logic reset1;
	logic sync;
	fg_pkg::play_window_t window;
	fg_pkg::mem_write_t host_write;
	logic host_write_strobe;
	logic [`FG_CHANNELS-1:0] bits_out;
	logic word_strobe;
	logic load_done;

	// reference model state
	fg_pkg::word_t model_mem [`FG_CHANNELS][WORDS];
	fg_pkg::word_t expected_word [`FG_CHANNELS];
	fg_pkg::word_t rebuilt [`FG_CHANNELS];
	fg_pkg::word_t finished_word [`FG_CHANNELS];
	fg_pkg::word_t finished_expected [`FG_CHANNELS];
	fg_pkg::addr_t expected_address;
	fg_pkg::addr_t strobe_address;
	logic restart_due;
	logic model_playing;
	logic collecting;
	logic word_ready;
	int bit_index;
	int strobe_count;
	int strobe_gap;
	int words_checked;
	int cycles_since_reset;
	int cycle_count = 0;
	int unsigned random_state;

	fg_top dut_i (
		.clock50(clock50),
		.reset1(reset1),
		.sync(sync),
		.window(window),
		.host_write(host_write),
		.host_write_strobe(host_write_strobe),
		.bits_out(bits_out),
		.word_strobe(word_strobe),
		.load_done(load_done)
	);

	always #2 clock50 = ~clock50;

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1);
	endtask

	// thermometer from the msb on pulse slots, else empty
	function automatic fg_pkg::word_t expected_pattern(input int channel, input int address);
		int ones;
		fg_pkg::word_t all_ones;
		all_ones = '1;
		if (address % `FG_PULSE_SPACING != 0) begin
			return '0;
		end
		ones = 1 + ((address / `FG_PULSE_SPACING + channel) % `FG_WORD_BITS);
		return ~(all_ones >> ones);
	endfunction

	// lcg, upper bits only
	function automatic int unsigned next_random();
		random_state = random_state * 32'd1103515245 + 32'd12345;
		return random_state >> 16;
	endfunction

	// cycle limit
	always @(posedge clock50) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			fail_run($sformatf("run timed out after %0d cycles", cycle_count));
		end
	end

	always @(posedge clock50) begin
		if (reset1) begin
			cycles_since_reset <= 0;
		end else begin
			cycles_since_reset <= cycles_since_reset + 1;
		end
	end

	// clocks since the last word strobe, zero before the first
	always @(posedge clock50) begin
		if (reset1) begin
			strobe_gap <= 0;
		end else if (word_strobe) begin
			strobe_gap <= 1;
		end else if (strobe_gap != 0) begin
			strobe_gap <= strobe_gap + 1;
		end
	end

	// model: pattern memory, play order and word rebuild
	always @(posedge clock50) begin
		if (reset1) begin
			for (int c = 0; c < `FG_CHANNELS; c++) begin
				for (int a = 0; a < WORDS; a++) begin
					model_mem[c][a] <= expected_pattern(c, a);
				end
			end
			expected_address <= '0;
			restart_due <= 1'b0;
			model_playing <= 1'b0;
			collecting <= 1'b0;
			word_ready <= 1'b0;
			bit_index <= 0;
			strobe_count <= 0;
			words_checked <= 0;
		end else begin
			word_ready <= 1'b0;
			// host writes count only once loaded
			if (host_write_strobe && load_done) begin
				model_mem[host_write.channel][host_write.address] <= host_write.data;
			end
			if (word_strobe) begin
				strobe_count <= strobe_count + 1;
				// restart lands on the start word, else step with wrap
				if (restart_due || expected_address == window.end_address) begin
					strobe_address = window.start_address;
				end else begin
					strobe_address = expected_address + 1'b1;
				end
				expected_address <= strobe_address;
				for (int c = 0; c < `FG_CHANNELS; c++) begin
					expected_word[c] <= (model_playing || restart_due)
						? model_mem[c][strobe_address] : '0;
					rebuilt[c] <= {{(`FG_WORD_BITS-1){1'b0}}, bits_out[c]};
				end
				if (restart_due) begin
					model_playing <= 1'b1;
					restart_due <= 1'b0;
				end
				collecting <= 1'b1;
				bit_index <= 1;
			end else if (collecting) begin
				for (int c = 0; c < `FG_CHANNELS; c++) begin
					rebuilt[c] <= {rebuilt[c][`FG_WORD_BITS-2:0], bits_out[c]};
				end
				// lsb arrives, word complete
				if (bit_index == `FG_WORD_BITS - 1) begin
					for (int c = 0; c < `FG_CHANNELS; c++) begin
						finished_word[c] <= {rebuilt[c][`FG_WORD_BITS-2:0], bits_out[c]};
						finished_expected[c] <= expected_word[c];
					end
					collecting <= 1'b0;
					word_ready <= 1'b1;
					words_checked <= words_checked + 1;
				end
				bit_index <= bit_index + 1;
			end
			if (sync) begin
				restart_due <= 1'b1;
			end
		end
	end

	// load takes one clock per word of every channel
	// low through the load, high from then on
	load_done_timing: assert property (
		@(posedge clock50) disable iff (reset1)
		load_done == (cycles_since_reset >= LOAD_CYCLES)
	) else fail_run($sformatf("ERR load_done expected %h got %h",
		$sampled(cycles_since_reset) >= LOAD_CYCLES, $sampled(load_done)));

	strobe_quiet_before_load: assert property (
		@(posedge clock50) disable iff (reset1)
		!load_done |-> !word_strobe
	) else fail_run($sformatf("ERR word_strobe expected %h got %h", 1'b0, $sampled(word_strobe)));

	bits_quiet_before_load: assert property (
		@(posedge clock50) disable iff (reset1)
		!load_done |-> (bits_out == '0)
	) else fail_run($sformatf("ERR bits_out expected %h got %h", 0, $sampled(bits_out)));

	// one word period between strobes
	strobe_period: assert property (
		@(posedge clock50) disable iff (reset1)
		(strobe_gap != 0) |-> (word_strobe == (strobe_gap == `FG_WORD_BITS))
	) else fail_run($sformatf("ERR word_strobe expected %h got %h",
		$sampled(strobe_gap) == `FG_WORD_BITS, $sampled(word_strobe)));

	// one word check per channel
	for (genvar c = 0; c < `FG_CHANNELS; c++) begin : check_gen
		word_matches: assert property (
			@(posedge clock50) disable iff (reset1)
			word_ready |-> (finished_word[c] == finished_expected[c])
		) else fail_run($sformatf("ERR word[%0d] expected %h got %h",
			c, finished_expected[c], finished_word[c]));
	end

	// returns on the falling edge after the count-th strobe
	task automatic wait_strobes(input int count);
		int target;
		target = strobe_count + count;
		while (strobe_count < target) begin
			@(negedge clock50);
		end
	endtask

	task automatic write_host(input int channel, input int address, input fg_pkg::word_t data);
		host_write.channel = fg_pkg::chan_t'(channel);
		host_write.address = fg_pkg::addr_t'(address);
		host_write.data = data;
		host_write_strobe = 1'b1;
		@(negedge clock50);
		host_write_strobe = 1'b0;
	endtask

	// new window and sync just after a strobe
	task automatic start_playback(input int first, input int last);
		wait_strobes(1);
		window.start_address = fg_pkg::addr_t'(first);
		window.end_address = fg_pkg::addr_t'(last);
		sync = 1'b1;
		@(negedge clock50);
		sync = 1'b0;
	endtask

	// random window, at most 16 words
	task automatic pick_window(output int first, output int last);
		first = next_random() % WORDS;
		last = first + (next_random() % 16);
		if (last > WORDS - 1) begin
			last = WORDS - 1;
		end
	endtask

	initial begin
		int first;
		int last;
		int length;
		int address;
		random_state = 14444;
		reset1 = 1'b1;
		sync = 1'b0;
		window = '0;
		host_write = '0;
		host_write_strobe = 1'b0;
		repeat (8) @(negedge clock50);
		reset1 = 1'b0;

		// write during the load, channel 0 already filled, must be dropped
		repeat (150) @(negedge clock50);
		address = next_random() % WORDS;
		write_host(0, address, ~expected_pattern(0, address));
		while (!load_done) begin
			@(negedge clock50);
		end

		// muted words before any sync
		wait_strobes(4);

		// full window, one pass plus the wrap
		start_playback(0, WORDS - 1);
		wait_strobes(WORDS + 3);

		// random window, then a restart part way through
		pick_window(first, last);
		length = last - first + 1;
		start_playback(first, last);
		wait_strobes(length + length / 2 + 1);
		start_playback(first, last);
		wait_strobes(length + 2);

		// host overwrites inside the window, seen on the next pass
		repeat (3) begin
			pick_window(first, last);
			length = last - first + 1;
			start_playback(first, last);
			wait_strobes(1);
			address = first + (next_random() % length);
			write_host(next_random() % `FG_CHANNELS, address, fg_pkg::word_t'(next_random()));
			wait_strobes(length + 2);
		end

		if (words_checked >= MIN_WORDS) begin
			$display("All tests passed");
			$finish;
		end else begin
			fail_run($sformatf("only %0d words were rebuilt and checked", words_checked));
		end
	end

endmodule

`default_nettype wire

// ==== verilog/fg_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fg_cfg.svh"

// bunch pattern generator top
// loader fills the channel memories, serializer clocks them out
module fg_top (
	input wire logic clock50,
	input wire logic reset1,
	// one-cycle restart pulse
	input wire logic sync,
	// loop window, held while playing
	input wire fg_pkg::play_window_t window,
	// single-word overwrite from the host
	input wire fg_pkg::mem_write_t host_write,
	input wire logic host_write_strobe,
	// one serial bit per channel
	output logic [`FG_CHANNELS-1:0] bits_out,
	// marks the msb of each word on bits_out
	output logic word_strobe,
	// initial pattern written
	output logic load_done
);

	// shared write bus to all memories
	fg_pkg::mem_write_t mem_write;
	logic mem_write_strobe;

	// read request, one pulse per word period
	logic fetch;

	// words read back, one per channel
	fg_pkg::word_t [`FG_CHANNELS-1:0] words;

	pattern_loader loader_i (
		.clock50(clock50),
		.reset1(reset1),
		.host_write(host_write),
		.host_write_strobe(host_write_strobe),
		.mem_write(mem_write),
		.mem_write_strobe(mem_write_strobe),
		.load_done(load_done)
	);

	// one memory and read pointer per channel
	for (genvar i = 0; i < `FG_CHANNELS; i++) begin : channel_gen
		playback_channel #(
			.channel_index(i)
		) channel_i (
			.clock50(clock50),
			.reset1(reset1),
			.mem_write(mem_write),
			.mem_write_strobe(mem_write_strobe),
			.window(window),
			.sync(sync),
			.fetch(fetch),
			.word(words[i])
		);
	end

	word_serializer serializer_i (
		.clock50(clock50),
		.reset1(reset1),
		.load_done(load_done),
		.words(words),
		.fetch(fetch),
		.word_strobe(word_strobe),
		.bits_out(bits_out)
	);

endmodule

`default_nettype wire

// ==== serializer/word_serializer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fg_cfg.svh"

// fetches one word per channel every word period
// and shifts it out msb first, one bit per clock
module word_serializer (
	input wire logic clock50,
	input wire logic reset1,
	input wire logic load_done,
	input wire fg_pkg::word_t [`FG_CHANNELS-1:0] words,
	output logic fetch,
	output logic word_strobe,
	output logic [`FG_CHANNELS-1:0] bits_out
);

	// position within the word period
	logic [$clog2(`FG_WORD_BITS)-1:0] phase;

	// fetch delayed by one, channel words valid now
	logic load_shift;

	fg_pkg::word_t shift_reg [`FG_CHANNELS];

	// free-running modulo counter once the memories are loaded
	always_ff @(posedge clock50) begin
		if (reset1) begin
			phase <= '0;
		end else if (load_done) begin
			if (phase == `FG_WORD_BITS - 1) begin
				phase <= '0;
			end else begin
				phase <= phase + 1'b1;
			end
		end
	end

	assign fetch = load_done && (phase == '0);

	// load one cycle after the channel read, strobe with the msb
	always_ff @(posedge clock50) begin
		if (reset1) begin
			load_shift <= 1'b0;
			word_strobe <= 1'b0;
			for (int i = 0; i < `FG_CHANNELS; i++) begin
				shift_reg[i] <= '0;
			end
		end else begin
			load_shift <= fetch;
			word_strobe <= load_shift;
			for (int i = 0; i < `FG_CHANNELS; i++) begin
				if (load_shift) begin
					shift_reg[i] <= words[i];
				end else begin
					shift_reg[i] <= {shift_reg[i][`FG_WORD_BITS-2:0], 1'b0};
				end
			end
		end
	end

	// msb of each shifter drives its output
	always_comb begin
		for (int i = 0; i < `FG_CHANNELS; i++) begin
			bits_out[i] = shift_reg[i][`FG_WORD_BITS-1];
		end
	end

	// fetch and strobe sit two phases apart
	fetch_strobe_apart: assert property (
		@(posedge clock50) disable iff (reset1)
		!(fetch && word_strobe)
	);

endmodule

`default_nettype wire

// ==== channel/playback_channel.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fg_cfg.svh"

// one playback channel
// pattern memory plus a read pointer looping over the shared window
module playback_channel #(
	// which channel field of the write bus this memory answers to
	parameter int channel_index = 0
) (
	input wire logic clock50,
	input wire logic reset1,
	input wire fg_pkg::mem_write_t mem_write,
	input wire logic mem_write_strobe,
	input wire fg_pkg::play_window_t window,
	input wire logic sync,
	input wire logic fetch,
	// valid from the cycle after fetch
	output fg_pkg::word_t word
);

	// pattern memory, fully written by the loader before any fetch
	fg_pkg::word_t memory [2**`FG_ADDR_BITS];

	// next address to play
	fg_pkg::addr_t read_pointer;
	fg_pkg::addr_t read_address;
	fg_pkg::addr_t next_address;

	// sync seen, restart at the next fetch
	logic restart_pending;
	// set by the first restart, unmutes the output
	logic playing;

	logic write_hit;

	// only writes addressed to this channel
	assign write_hit = mem_write_strobe
		&& (mem_write.channel == fg_pkg::chan_t'(channel_index));

	always_ff @(posedge clock50) begin
		if (write_hit) begin
			memory[mem_write.address] <= mem_write.data;
		end
	end

	// a pending restart jumps straight to the window start
	assign read_address = restart_pending ? window.start_address : read_pointer;

	// wrap after the window end, end inclusive
	assign next_address = (read_address == window.end_address)
		? window.start_address
		: read_address + 1'b1;

	// pointer and sync state
	always_ff @(posedge clock50) begin
		if (reset1) begin
			read_pointer <= '0;
			restart_pending <= 1'b0;
			playing <= 1'b0;
		end else begin
			if (fetch) begin
				read_pointer <= next_address;
				if (restart_pending) begin
					restart_pending <= 1'b0;
					playing <= 1'b1;
				end
			end
			// sync wins over a coincident fetch, applied on the following one
			if (sync) begin
				restart_pending <= 1'b1;
			end
		end
	end

	// registered read, muted until the first sync
	always_ff @(posedge clock50) begin
		if (fetch) begin
			word <= (playing || restart_pending) ? memory[read_address] : '0;
		end
	end

	// window has to be ordered whenever the pointer moves
	window_ordered: assert property (
		@(posedge clock50) disable iff (reset1)
		fetch |-> (window.end_address >= window.start_address)
	);

endmodule

`default_nettype wire

// ==== loader/pattern_loader.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fg_cfg.svh"

// fills every channel memory with the bunch pattern after reset
// then hands the write bus over to the host
module pattern_loader (
	input wire logic clock50,
	input wire logic reset1,
	input wire fg_pkg::mem_write_t host_write,
	input wire logic host_write_strobe,
	output fg_pkg::mem_write_t mem_write,
	output logic mem_write_strobe,
	output logic load_done
);

	// walk position, channel-major
	fg_pkg::chan_t walk_channel;
	fg_pkg::addr_t walk_address;
	logic last_word;

	// thermometer pulse from the msb on every pulse slot, zero elsewhere
	// pulse width steps with the slot number, offset by channel
	function automatic fg_pkg::word_t pattern_word(
		input fg_pkg::chan_t channel,
		input fg_pkg::addr_t address
	);
		int unsigned ones;
		fg_pkg::word_t word;
		word = '0;
		if (address % `FG_PULSE_SPACING == 0) begin
			ones = 1 + ((address / `FG_PULSE_SPACING + channel) % `FG_WORD_BITS);
			for (int i = 0; i < `FG_WORD_BITS; i++) begin
				if (i < ones) begin
					word[`FG_WORD_BITS-1-i] = 1'b1;
				end
			end
		end
		return word;
	endfunction

	// last address of the last channel
	assign last_word = (walk_channel == fg_pkg::chan_t'(`FG_CHANNELS - 1)) && (&walk_address);

	// walk counter, strobe and done flag
	always_ff @(posedge clock50) begin
		if (reset1) begin
			walk_channel <= '0;
			walk_address <= '0;
			mem_write_strobe <= 1'b0;
			load_done <= 1'b0;
		end else if (!load_done) begin
			// one word per clock during the load
			mem_write_strobe <= 1'b1;
			if (last_word) begin
				load_done <= 1'b1;
			end else begin
				walk_address <= walk_address + 1'b1;
				if (&walk_address) begin
					walk_channel <= walk_channel + 1'b1;
				end
			end
		end else begin
			// host strobes only count once loaded
			mem_write_strobe <= host_write_strobe;
		end
	end

	// write payload, follows whoever owns the bus
	always_ff @(posedge clock50) begin
		if (!load_done) begin
			mem_write.channel <= walk_channel;
			mem_write.address <= walk_address;
			mem_write.data <= pattern_word(walk_channel, walk_address);
		end else if (host_write_strobe) begin
			mem_write <= host_write;
		end
	end

	// a write to a channel that does not exist would be lost silently
	channel_in_range: assert property (
		@(posedge clock50) disable iff (reset1)
		$rose(mem_write_strobe) |-> (mem_write.channel < `FG_CHANNELS)
	);

endmodule

`default_nettype wire

// ==== common/fg_pkg.sv ====
`default_nettype none

`include "fg_cfg.svh"

// shared types of the pattern generator
package fg_pkg;

	// one playback word, shifted out msb first
	typedef logic [`FG_WORD_BITS-1:0] word_t;

	// playback memory address
	typedef logic [`FG_ADDR_BITS-1:0] addr_t;

	// channel index
	// wide enough for the 4 channels of this build
	typedef logic [1:0] chan_t;

	// write command to the playback memories
	// every channel sees it, only the addressed one takes it
	typedef struct packed {
		chan_t channel;
		addr_t address;
		word_t data;
	} mem_write_t;

	// loop window shared by all channels
	// both ends inclusive, end not below start
	typedef struct packed {
		addr_t start_address;
		addr_t end_address;
	} play_window_t;

endpackage

`default_nettype wire

// ==== common/fg_cfg.svh ====
`ifndef FG_CFG_SVH
`define FG_CFG_SVH

// build-time sizing of the pattern generator

// playback channels, one serial output each
`define FG_CHANNELS 4

// playback memory address width
// 6 bits gives 64 words per channel
`define FG_ADDR_BITS 6

// word width, also the serializer period in clocks
`define FG_WORD_BITS 8

// distance between bunch pulses, in words
// addresses that are a multiple of this carry a pulse
`define FG_PULSE_SPACING 8

`endif
